/* source/dcache_pkg.sv */
package dcache_pkg;

	localparam int NUM_SETS = 64;

	typedef logic [31:0] word_t;
	typedef logic [21:0] tag_t;
	typedef logic [5:0] index_t;

	// byte address as seen by the requester
	typedef struct packed {
		tag_t			tag;
		index_t			index;
		logic [1:0]		word_off;
		logic [1:0]		byte_off;
	} cache_addr_t;

	// word 0 sits in the low bits
	typedef word_t [3:0] way_line_t;
	typedef way_line_t [1:0] data_line_t;

	typedef struct packed {
		logic			valid;
		logic			dirty;
		tag_t			tag;
	} way_flag_t;

	// lru names the way to replace next
	typedef struct packed {
		way_flag_t [1:0]	entry;
		logic				lru;
	} flag_line_t;

	typedef struct packed {
		logic			valid;
		logic			wr;
		logic [27:0]	line_addr;
		way_line_t		line;
	} mem_req_t;

	typedef enum logic [2:0] {
		IDLE,
		CHECK,
		EVICT,
		LOAD,
		DONE
	} ctrl_state_t;

	typedef enum logic [1:0] {
		NONE,
		STORE,
		FILL,
		TOUCH
	} update_op_t;

endpackage

/* source/dcache_array.sv */
`timescale 1ns/10ps

module dcache_array (
	input logic					clk_50m,
	input logic					rst_n,
	input logic					rd_en,
	input logic					wr_en,
	input dcache_pkg::index_t		index,
	input dcache_pkg::flag_line_t	flag_in,
	input dcache_pkg::data_line_t	data_in,
	output dcache_pkg::flag_line_t	flag_out,
	output dcache_pkg::data_line_t	data_out
);

	import dcache_pkg::*;

	flag_line_t flag_mem [NUM_SETS];
	data_line_t data_mem [NUM_SETS];

	// every line starts invalid
	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				flag_mem[i] <= '0;
			end
			flag_out <= '0;
		end else begin
			if (wr_en) begin
				flag_mem[index] <= flag_in;
			end
			// read during write returns the new line
			if (rd_en) begin
				if (wr_en) begin
					flag_out <= flag_in;
				end else begin
					flag_out <= flag_mem[index];
				end
			end
		end
	end

	always_ff @(posedge clk_50m) begin
		if (wr_en) begin
			data_mem[index] <= data_in;
		end
		if (rd_en) begin
			if (wr_en) begin
				data_out <= data_in;
			end else begin
				data_out <= data_mem[index];
			end
		end
	end

endmodule

/* source/dcache_hit_check.sv */
`timescale 1ns/10ps

module dcache_hit_check (
	input dcache_pkg::flag_line_t	flags,
	input dcache_pkg::tag_t		tag,
	output logic					hit,
	output logic					hit_way,
	output logic					victim_dirty
);

	import dcache_pkg::*;

	logic hit0;
	logic hit1;
	way_flag_t victim;

	always_comb begin
		hit0 = flags.entry[0].valid && (flags.entry[0].tag == tag);
		hit1 = flags.entry[1].valid && (flags.entry[1].tag == tag);
	end

	always_comb begin
		hit = hit0 || hit1;
		// way 1 only when way 0 misses
		if (hit0) begin
			hit_way = 1'b0;
		end else begin
			hit_way = hit1;
		end
	end

	// victim is the lru way
	always_comb begin
		victim = flags.entry[flags.lru];
		victim_dirty = victim.dirty;
	end

endmodule

/* source/dcache_line_update.sv */
`timescale 1ns/10ps

module dcache_line_update (
	input dcache_pkg::update_op_t	op,
	input logic					way,
	input logic [1:0]				word_off,
	input dcache_pkg::tag_t		tag,
	input dcache_pkg::word_t		wdata,
	input dcache_pkg::way_line_t	fill,
	input dcache_pkg::data_line_t	data_cur,
	input dcache_pkg::flag_line_t	flags_cur,
	output dcache_pkg::data_line_t	data_next,
	output dcache_pkg::flag_line_t	flags_next,
	output dcache_pkg::word_t		rdata
);

	import dcache_pkg::*;

	way_line_t cur_way;

	always_comb begin
		cur_way = data_cur[way];
		rdata = cur_way[word_off];
	end

	always_comb begin
		data_next = data_cur;
		flags_next = flags_cur;

		case (op)
			STORE: begin
				// one word and the way becomes dirty
				data_next[way][word_off] = wdata;
				flags_next.entry[way].valid = 1'b1;
				flags_next.entry[way].dirty = 1'b1;
				flags_next.lru = ~way;
			end

			FILL: begin
				// whole line from memory and marked clean
				data_next[way] = fill;
				flags_next.entry[way].valid = 1'b1;
				flags_next.entry[way].dirty = 1'b0;
				flags_next.entry[way].tag = tag;
			end

			TOUCH: begin
				flags_next.lru = ~way;
			end

			default: begin
				data_next = data_cur;
				flags_next = flags_cur;
			end
		endcase
	end

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl (
	input logic						clk_50m,
	input logic						rst_n,
	input dcache_pkg::cache_addr_t		addr,
	input logic						rd,
	input logic						wr,
	input logic						valid,
	input dcache_pkg::word_t			data_in,
	input dcache_pkg::flag_line_t		array_flags,
	input dcache_pkg::data_line_t		array_data,
	input logic						hit,
	input logic						hit_way,
	input logic						victim_dirty,
	input dcache_pkg::word_t			rdata,
	input logic						mem_ack,
	input dcache_pkg::way_line_t		rline,
	output dcache_pkg::flag_line_t		held_flags,
	output dcache_pkg::data_line_t		held_data,
	output logic						arr_rd,
	output logic						arr_wr,
	output dcache_pkg::update_op_t		op,
	output logic						way,
	output logic						mem_start,
	output logic						mem_wr,
	output logic [27:0]				mem_line_addr,
	output dcache_pkg::way_line_t		evict_line,
	output dcache_pkg::word_t			data_out,
	output logic						done
);

	import dcache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic mem_pend;
	logic victim;

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			mem_pend <= 1'b0;
		end else begin
			state <= next_state;
			if (mem_ack) begin
				mem_pend <= 1'b0;
			end else if (mem_start) begin
				mem_pend <= 1'b1;
			end
		end
	end

	// the array keeps its last read lines until the next read
	always_comb begin
		held_flags = array_flags;
		held_data = array_data;
		victim = held_flags.lru;
	end

	always_comb begin
		next_state = state;
		arr_rd = 1'b0;
		arr_wr = 1'b0;
		op = NONE;
		way = hit_way;
		mem_start = 1'b0;
		mem_wr = 1'b0;

		case (state)
			IDLE: begin
				if (valid && (rd || wr)) begin
					arr_rd = 1'b1;
					next_state = CHECK;
				end
			end

			CHECK: begin
				if (hit) begin
					next_state = DONE;
				end else if (held_flags.entry[victim].valid && victim_dirty) begin
					next_state = EVICT;
				end else begin
					next_state = LOAD;
				end
			end

			EVICT: begin
				way = victim;
				mem_wr = 1'b1;
				mem_start = !mem_pend;
				if (mem_ack) begin
					next_state = LOAD;
				end
			end

			LOAD: begin
				way = victim;
				mem_start = !mem_pend;
				// fill and read back the set in one cycle
				if (mem_ack) begin
					op = FILL;
					arr_wr = 1'b1;
					arr_rd = 1'b1;
					next_state = DONE;
				end
			end

			DONE: begin
				op = wr ? STORE : TOUCH;
				arr_wr = 1'b1;
				next_state = IDLE;
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// write back goes to the victim's own line
	always_comb begin
		if (state == EVICT) begin
			mem_line_addr = {held_flags.entry[victim].tag, addr.index};
		end else begin
			mem_line_addr = {addr.tag, addr.index};
		end
		evict_line = held_data[victim];
	end

	always_comb begin
		done = (state == DONE);
		data_out = rd ? rdata : data_in;
	end

endmodule

/* source/dcache_mem_port.sv */
`timescale 1ns/10ps

module dcache_mem_port (
	input logic					clk_50m,
	input logic					rst_n,
	input logic					start,
	input logic					wr,
	input logic [27:0]			line_addr,
	input dcache_pkg::way_line_t	wline,
	output dcache_pkg::mem_req_t	mem_req,
	input dcache_pkg::way_line_t	mem_rdata,
	input logic					mem_done,
	output logic					ack,
	output dcache_pkg::way_line_t	rline
);

	import dcache_pkg::*;

	logic req_valid;
	logic req_wr;
	logic [27:0] req_addr;
	way_line_t req_line;

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			req_valid <= 1'b0;
			ack <= 1'b0;
		end else begin
			ack <= req_valid && mem_done;
			if (req_valid && mem_done) begin
				req_valid <= 1'b0;
			end else if (start) begin
				req_valid <= 1'b1;
			end
		end
	end

	// request held constant until memory completes
	always_ff @(posedge clk_50m) begin
		if (start && !req_valid) begin
			req_wr <= wr;
			req_addr <= line_addr;
			req_line <= wline;
		end
		if (req_valid && mem_done && !req_wr) begin
			rline <= mem_rdata;
		end
	end

	always_comb begin
		mem_req.valid = req_valid;
		mem_req.wr = req_wr;
		mem_req.line_addr = req_addr;
		mem_req.line = req_line;
	end

endmodule

/* source/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top (
	input logic					clk_50m,
	input logic					rst_n,
	input dcache_pkg::cache_addr_t	addr,
	input dcache_pkg::word_t		data_in,
	input logic					rd,
	input logic					wr,
	input logic					valid,
	output dcache_pkg::word_t		data_out,
	output logic					done,
	output dcache_pkg::mem_req_t	mem_req,
	input dcache_pkg::way_line_t	mem_rdata,
	input logic					mem_done
);

	import dcache_pkg::*;

	flag_line_t array_flags;
	flag_line_t held_flags;
	flag_line_t flags_next;
	data_line_t array_data;
	data_line_t held_data;
	data_line_t data_next;
	logic arr_rd;
	logic arr_wr;
	update_op_t op;
	logic way;
	logic hit;
	logic hit_way;
	logic victim_dirty;
	word_t rdata;
	logic mem_start;
	logic mem_wr;
	logic [27:0] mem_line_addr;
	way_line_t evict_line;
	logic mem_ack;
	way_line_t rline;

	dcache_array i_array (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.rd_en		(arr_rd),
		.wr_en		(arr_wr),
		.index		(addr.index),
		.flag_in	(flags_next),
		.data_in	(data_next),
		.flag_out	(array_flags),
		.data_out	(array_data)
	);

	dcache_hit_check i_hit_check (
		.flags			(held_flags),
		.tag			(addr.tag),
		.hit			(hit),
		.hit_way		(hit_way),
		.victim_dirty	(victim_dirty)
	);

	dcache_line_update i_line_update (
		.op			(op),
		.way		(way),
		.word_off	(addr.word_off),
		.tag		(addr.tag),
		.wdata		(data_in),
		.fill		(rline),
		.data_cur	(held_data),
		.flags_cur	(held_flags),
		.data_next	(data_next),
		.flags_next	(flags_next),
		.rdata		(rdata)
	);

	dcache_ctrl i_ctrl (
		.clk_50m		(clk_50m),
		.rst_n			(rst_n),
		.addr			(addr),
		.rd				(rd),
		.wr				(wr),
		.valid			(valid),
		.data_in		(data_in),
		.array_flags	(array_flags),
		.array_data		(array_data),
		.hit			(hit),
		.hit_way		(hit_way),
		.victim_dirty	(victim_dirty),
		.rdata			(rdata),
		.mem_ack		(mem_ack),
		.rline			(rline),
		.held_flags		(held_flags),
		.held_data		(held_data),
		.arr_rd			(arr_rd),
		.arr_wr			(arr_wr),
		.op				(op),
		.way			(way),
		.mem_start		(mem_start),
		.mem_wr			(mem_wr),
		.mem_line_addr	(mem_line_addr),
		.evict_line		(evict_line),
		.data_out		(data_out),
		.done			(done)
	);

	dcache_mem_port i_mem_port (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.start		(mem_start),
		.wr			(mem_wr),
		.line_addr	(mem_line_addr),
		.wline		(evict_line),
		.mem_req	(mem_req),
		.mem_rdata	(mem_rdata),
		.mem_done	(mem_done),
		.ack		(mem_ack),
		.rline		(rline)
	);

endmodule

/* tests/dcache_checker.sv */
`timescale 1ns/10ps

module dcache_checker (
	input logic						clk_50m,
	input logic						rst_n,
	input dcache_pkg::cache_addr_t	addr,
	input dcache_pkg::word_t		data_in,
	input logic						rd,
	input logic						wr,
	input logic						valid,
	input dcache_pkg::word_t		data_out,
	input logic						done,
	input dcache_pkg::mem_req_t		mem_req,
	input logic						mem_done,
	output int						errors,
	output int						checks
);

	import dcache_pkg::*;

	// one flag line per set plus every word ever written
	flag_line_t model_flags [NUM_SETS];
	word_t words [logic [29:0]];

	logic busy;
	int latency;
	logic exp_hit;
	logic exp_is_rd;
	word_t exp_rdata;
	logic exp_wb;
	logic [27:0] wb_addr;
	way_line_t wb_line;
	logic exp_load;
	logic [27:0] load_addr;
	logic held;
	mem_req_t prev_req;

	function automatic word_t pattern_word(input logic [29:0] word_addr);
		return {word_addr, 2'b01} ^ 32'hc3a5_0f96;
	endfunction

	function automatic word_t read_word(input logic [29:0] word_addr);
		if (words.exists(word_addr)) begin
			return words[word_addr];
		end
		return pattern_word(word_addr);
	endfunction

	task automatic report_problem(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic compare_value(input string name, input logic [127:0] expected,
			input logic [127:0] seen);
		checks++;
		if (seen !== expected) begin
			$display("[FAIL] %0t %s expected %0h seen %0h", $time, name, expected, seen);
			errors++;
		end
	endtask

	task automatic accept_request();
		logic hit0;
		logic hit1;
		logic way;
		index_t idx;
		logic [27:0] line_addr;
		idx = addr.index;
		line_addr = {addr.tag, addr.index};
		hit0 = model_flags[idx].entry[0].valid && (model_flags[idx].entry[0].tag == addr.tag);
		hit1 = model_flags[idx].entry[1].valid && (model_flags[idx].entry[1].tag == addr.tag);
		exp_hit = hit0 || hit1;
		way = !hit0;
		exp_wb = 1'b0;
		exp_load = 1'b0;
		if (!exp_hit) begin
			way = model_flags[idx].lru;
			// dirty victim goes back to memory first
			if (model_flags[idx].entry[way].valid && model_flags[idx].entry[way].dirty) begin
				exp_wb = 1'b1;
				wb_addr = {model_flags[idx].entry[way].tag, idx};
				for (int w = 0; w < 4; w++) begin
					wb_line[w] = read_word({wb_addr, w[1:0]});
				end
			end
			exp_load = 1'b1;
			load_addr = line_addr;
			model_flags[idx].entry[way].valid = 1'b1;
			model_flags[idx].entry[way].dirty = 1'b0;
			model_flags[idx].entry[way].tag = addr.tag;
		end
		exp_is_rd = rd;
		exp_rdata = read_word({line_addr, addr.word_off});
		if (wr) begin
			words[{line_addr, addr.word_off}] = data_in;
			model_flags[idx].entry[way].dirty = 1'b1;
		end
		model_flags[idx].lru = ~way;
		busy = 1'b1;
		latency = 0;
	endtask

	task automatic check_mem_event();
		if (exp_wb) begin
			compare_value("mem_req.wr", 128'(1'b1), 128'(mem_req.wr));
			compare_value("mem_req.line_addr", 128'(wb_addr), 128'(mem_req.line_addr));
			compare_value("mem_req.line", wb_line, mem_req.line);
			exp_wb = 1'b0;
		end else if (exp_load) begin
			compare_value("mem_req.wr", 128'(1'b0), 128'(mem_req.wr));
			compare_value("mem_req.line_addr", 128'(load_addr), 128'(mem_req.line_addr));
			exp_load = 1'b0;
		end else begin
			report_problem("memory request completed that the model did not expect");
		end
	endtask

	task automatic watch_memory();
		if (mem_req.valid) begin
			if (!busy || exp_hit) begin
				report_problem("memory request issued without a pending miss");
			end else if (held && (mem_req !== prev_req)) begin
				report_problem("memory request changed before mem_done");
			end
			if (mem_done) begin
				check_mem_event();
				held = 1'b0;
			end else begin
				held = 1'b1;
			end
			prev_req = mem_req;
		end else begin
			held = 1'b0;
		end
	endtask

	task automatic finish_request();
		if (!busy) begin
			report_problem("done raised with no request pending");
		end else begin
			if (exp_hit) begin
				compare_value("done latency", 128'(2), 128'(latency));
			end
			if (exp_wb || exp_load) begin
				report_problem("done raised before the memory transfers completed");
			end
			if (exp_is_rd) begin
				compare_value("data_out", 128'(exp_rdata), 128'(data_out));
			end
			busy = 1'b0;
		end
	endtask

	// ports are stable at the falling edge
	always @(negedge clk_50m) begin
		if (!rst_n) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				model_flags[s] = '0;
			end
			words.delete();
			busy = 1'b0;
			exp_hit = 1'b0;
			exp_wb = 1'b0;
			exp_load = 1'b0;
			held = 1'b0;
		end else begin
			if (busy) begin
				latency++;
			end
			watch_memory();
			if (done) begin
				finish_request();
			end else if (!busy && valid && (rd || wr)) begin
				accept_request();
			end
		end
	end

endmodule

/* tests/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb;

	import dcache_pkg::*;

	localparam int DONE_TIMEOUT = 400;
	localparam int NUM_RANDOM = 300;
	localparam logic [31:0] SEED = 32'he54c7845;

	logic clk_50m;
	logic rst_n;
	cache_addr_t addr;
	word_t data_in;
	logic rd;
	logic wr;
	logic valid;
	word_t data_out;
	logic done;
	mem_req_t mem_req;
	way_line_t mem_rdata;
	logic mem_done;

	int errors;
	int checks;
	int timeouts;
	logic aborted;
	int long_delay;
	logic [31:0] stim_lfsr;
	logic [31:0] delay_lfsr;
	way_line_t mem_lines [logic [27:0]];
	tag_t tag_pool [4];
	index_t index_pool [2];

	dcache_top i_dut (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.addr		(addr),
		.data_in	(data_in),
		.rd			(rd),
		.wr			(wr),
		.valid		(valid),
		.data_out	(data_out),
		.done		(done),
		.mem_req	(mem_req),
		.mem_rdata	(mem_rdata),
		.mem_done	(mem_done)
	);

	dcache_checker i_checker (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.addr		(addr),
		.data_in	(data_in),
		.rd			(rd),
		.wr			(wr),
		.valid		(valid),
		.data_out	(data_out),
		.done		(done),
		.mem_req	(mem_req),
		.mem_done	(mem_done),
		.errors		(errors),
		.checks		(checks)
	);

	always #10 clk_50m = ~clk_50m;

	// galois lfsr stepped once per bit handed out
	function automatic logic [31:0] take_bits(inout logic [31:0] state, input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], state[0]};
			state = (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
		end
		return value;
	endfunction

	// never written lines read back as a function of their address
	function automatic way_line_t pattern_line(input logic [27:0] line_addr);
		way_line_t line;
		for (int w = 0; w < 4; w++) begin
			line[w] = {line_addr, w[1:0], 2'b01} ^ 32'hc3a5_0f96;
		end
		return line;
	endfunction

	task automatic serve_request();
		int delay;
		logic [27:0] line_addr;
		if (long_delay > 0) begin
			delay = long_delay;
		end else begin
			delay = int'(take_bits(delay_lfsr, 3));
		end
		repeat (delay) begin
			@(posedge clk_50m);
			#1;
		end
		line_addr = mem_req.line_addr;
		if (mem_req.wr) begin
			mem_lines[line_addr] = mem_req.line;
		end else if (mem_lines.exists(line_addr)) begin
			mem_rdata = mem_lines[line_addr];
		end else begin
			mem_rdata = pattern_line(line_addr);
		end
		mem_done = 1'b1;
		@(posedge clk_50m);
		#1;
		mem_done = 1'b0;
	endtask

	// backing memory
	initial begin
		@(posedge clk_50m);
		#1;
		forever begin
			if (rst_n && mem_req.valid) begin
				serve_request();
			end else begin
				@(posedge clk_50m);
				#1;
			end
		end
	end

	task automatic do_request(input logic is_wr, input tag_t tag, input index_t index,
			input logic [1:0] word_off, input word_t wdata);
		int cycles;
		if (!aborted) begin
			addr = {tag, index, word_off, 2'b00};
			data_in = wdata;
			rd = !is_wr;
			wr = is_wr;
			valid = 1'b1;
			cycles = 0;
			do begin
				@(posedge clk_50m);
				#1;
				cycles++;
			end while (!done && cycles < DONE_TIMEOUT);
			if (done) begin
				@(posedge clk_50m);
				#1;
				valid = 1'b0;
				rd = 1'b0;
				wr = 1'b0;
			end else begin
				$display("ERROR at %0t: no done within %0d cycles", $time, DONE_TIMEOUT);
				timeouts++;
				aborted = 1'b1;
			end
		end
	endtask

	// C evicts dirty A and A then comes back from memory
	task automatic lru_eviction_order();
		do_request(1'b1, tag_pool[0], index_pool[0], 2'd1, 32'h1111_aaaa);
		do_request(1'b1, tag_pool[1], index_pool[0], 2'd2, 32'h2222_bbbb);
		do_request(1'b0, tag_pool[2], index_pool[0], 2'd0, 32'h0);
		do_request(1'b0, tag_pool[1], index_pool[0], 2'd2, 32'h0);
		do_request(1'b0, tag_pool[0], index_pool[0], 2'd1, 32'h0);
	endtask

	task automatic slow_memory_requests();
		long_delay = 30;
		do_request(1'b1, tag_pool[0], index_pool[1], 2'd2, 32'hdead_0001);
		do_request(1'b1, tag_pool[1], index_pool[1], 2'd3, 32'hdead_0002);
		do_request(1'b0, tag_pool[2], index_pool[1], 2'd2, 32'h0);
		do_request(1'b0, tag_pool[0], index_pool[1], 2'd2, 32'h0);
		long_delay = 0;
	endtask

	task automatic random_requests();
		logic [31:0] bits;
		logic is_wr;
		tag_t tag;
		index_t index;
		logic [1:0] word_off;
		word_t wdata;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			bits = take_bits(stim_lfsr, 1);
			is_wr = bits[0];
			bits = take_bits(stim_lfsr, 2);
			tag = tag_pool[bits[1:0]];
			bits = take_bits(stim_lfsr, 1);
			index = index_pool[bits[0]];
			bits = take_bits(stim_lfsr, 2);
			word_off = bits[1:0];
			wdata = take_bits(stim_lfsr, 32);
			do_request(is_wr, tag, index, word_off, wdata);
			bits = take_bits(stim_lfsr, 2);
			if (bits[1:0] == 2'd0) begin
				repeat (3) begin
					@(posedge clk_50m);
					#1;
				end
			end
		end
	endtask

	initial begin
		clk_50m = 1'b0;
		rst_n = 1'b0;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		valid = 1'b0;
		mem_rdata = '0;
		mem_done = 1'b0;
		timeouts = 0;
		aborted = 1'b0;
		long_delay = 0;
		stim_lfsr = SEED;
		delay_lfsr = SEED;
		// few tags and sets so that conflicts are common
		tag_pool[0] = 22'h0a5c3;
		tag_pool[1] = 22'h1f00e;
		tag_pool[2] = 22'h00321;
		tag_pool[3] = 22'h3c7d1;
		index_pool[0] = 6'd5;
		index_pool[1] = 6'd42;
		repeat (3) @(posedge clk_50m);
		#1;
		rst_n = 1'b1;
		@(posedge clk_50m);
		#1;
		lru_eviction_order();
		slow_memory_requests();
		random_requests();
		repeat (4) @(posedge clk_50m);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* tb.f */
source/dcache_pkg.sv
source/dcache_array.sv
source/dcache_hit_check.sv
source/dcache_line_update.sv
source/dcache_ctrl.sv
source/dcache_mem_port.sv
source/dcache_top.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module dcache_tb \
	-f tb.f \
	-o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
